// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_vector_datapath
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR) --top-module $(TOP)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/coef_regfile.sv ====
`timescale 1ns/1ps

module coef_regfile #(
    parameter int SIMD_DEGREE = 4,
    parameter int VRF_DEPTH   = 4
) (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_we,
    input  vdp_pkg::vop_e                    i_op,
    input  logic [vdp_pkg::IDX_W-1:0]        i_idx,
    input  vdp_pkg::lane_t                   i_imm,
    input  logic                             i_accept,
    output vdp_pkg::lane_t [SIMD_DEGREE-1:0] o_coef
);

    import vdp_pkg::*;

    localparam int PTR_W = (VRF_DEPTH > 1) ? $clog2(VRF_DEPTH) : 1;

    typedef lane_t [SIMD_DEGREE-1:0] vec_t;

    vec_t             vrf [VRF_DEPTH];  // coefficient entries
    logic             mul_mode;         // 0 = pass, 1 = multiply
    logic [PTR_W-1:0] rd_ptr;           // auto-increment read pointer
    logic [PTR_W-1:0] last_ptr;         // iteration count - 1
    logic [PTR_W-1:0] wr_idx;
    vec_t             ones;
    vec_t             bcast;

    assign wr_idx = PTR_W'(i_idx);

    always_comb begin
        for (int l = 0; l < SIMD_DEGREE; l++) begin
            ones[l]  = lane_t'(1);   // pass mode multiplies by one
            bcast[l] = i_imm;        // vmv immediate on every lane
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            mul_mode <= 1'b0;
            rd_ptr   <= '0;
            last_ptr <= '0;
            for (int e = 0; e < VRF_DEPTH; e++) begin
                vrf[e] <= '0;
            end
        end else if (i_we) begin
            case (i_op)
                VOP_VMV: begin
                    if (int'(i_idx) < VRF_DEPTH) begin
                        vrf[wr_idx] <= bcast;
                    end
                end
                VOP_VMUL: begin
                    mul_mode <= 1'b1;
                    rd_ptr   <= '0;                           // restart the cycle
                    last_ptr <= PTR_W'(i_imm - lane_t'(1));   // imm in 1 .. VRF_DEPTH
                end
                default: begin
                    // VOP_PASS
                    mul_mode <= 1'b0;
                    rd_ptr   <= '0;
                end
            endcase
        end else if (i_accept && mul_mode) begin
            // one step per beat taken by the stage
            rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
        end
    end

    assign o_coef = mul_mode ? vrf[rd_ptr] : ones;

endmodule

// ==== design/instr_loader.sv ====
`timescale 1ns/1ps

module instr_loader #(
    parameter int NUM_COL = 3
) (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_req,
    input  vdp_pkg::vop_e             i_op,
    input  logic [vdp_pkg::COL_W-1:0] i_col,
    input  logic [vdp_pkg::IDX_W-1:0] i_idx,
    input  vdp_pkg::lane_t            i_imm,
    output logic                      o_ack,
    output logic [NUM_COL-1:0]        o_col_we,
    output vdp_pkg::vop_e             o_op,
    output logic [vdp_pkg::IDX_W-1:0] o_idx,
    output vdp_pkg::lane_t            o_imm
);

    typedef enum logic {
        S_IDLE,   // waiting for req
        S_ACK     // ack high, waiting for req to drop
    } state_e;

    state_e             state;
    logic               take;       // instruction accepted this edge
    logic [NUM_COL-1:0] col_sel;

    assign take  = (state == S_IDLE) && i_req;
    assign o_ack = (state == S_ACK);

    // one-hot column decode, codes past NUM_COL select nothing
    always_comb begin
        for (int c = 0; c < NUM_COL; c++) begin
            col_sel[c] = (int'(i_col) == c);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= S_IDLE;
            o_col_we <= '0;
        end else begin
            o_col_we <= take ? col_sel : '0;  // single-cycle strobe
            case (state)
                S_IDLE: begin
                    if (i_req) begin
                        state <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (!i_req) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // fields captured together with the strobe
    always_ff @(posedge clk) begin
        if (take) begin
            o_op  <= i_op;
            o_idx <= i_idx;
            o_imm <= i_imm;
        end
    end

endmodule

// ==== design/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [63:0]
) (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_push,
    input  logic     i_pop,
    input  payload_t i_din,
    output payload_t o_dout,
    output logic     o_full,
    output logic     o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;    // occupancy
    logic             do_push;
    logic             do_pop;

    // pointer step with wrap, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = i_push && !o_full;   // push on full dropped
    assign do_pop  = i_pop && !o_empty;   // pop on empty dropped

    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);
    assign o_dout  = mem[rd_ptr];         // oldest entry

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

// ==== design/vdp_pkg.sv ====
package vdp_pkg;

    // one lane of a vector beat
    localparam int LANE_W = 16;

    // unsigned lane value, products keep the low LANE_W bits
    typedef logic [LANE_W-1:0] lane_t;

    // instruction opcodes
    // the immediate field is read differently per opcode:
    //   VOP_PASS  imm unused
    //   VOP_VMUL  imm = iteration count, 1 .. VRF_DEPTH
    //   VOP_VMV   imm = value broadcast to every lane of entry idx
    typedef enum logic [1:0] {
        VOP_PASS = 2'd0,  // forward beats unchanged
        VOP_VMUL = 2'd1,  // multiply by entry[pointer]
        VOP_VMV  = 2'd2   // write one coefficient entry
    } vop_e;

    // instruction field widths

    // register index, sized for a VRF_DEPTH of 4
    localparam int IDX_W = 2;

    // column select, one code past NUM_COL of 3 is left unused
    // and is acked without a write
    localparam int COL_W = 2;

endpackage

// ==== design/vec_pe.sv ====
`timescale 1ns/1ps

module vec_pe #(
    parameter int SIMD_DEGREE = 4
) (
    input  logic                             clk,
    input  logic                             i_rst,
    // upstream side
    input  logic                             i_valid,
    output logic                             o_ready,
    input  vdp_pkg::lane_t [SIMD_DEGREE-1:0] i_data,
    // coefficient of this column
    input  vdp_pkg::lane_t [SIMD_DEGREE-1:0] i_coef,
    output logic                             o_accept,
    // downstream side
    output logic                             o_valid,
    input  logic                             i_ready,
    output vdp_pkg::lane_t [SIMD_DEGREE-1:0] o_data
);

    import vdp_pkg::*;

    lane_t [SIMD_DEGREE-1:0] prod;

    // take a beat when empty or when the held beat leaves this cycle
    assign o_ready  = !o_valid || i_ready;
    assign o_accept = i_valid && o_ready;

    // lane-wise product, low LANE_W bits kept
    always_comb begin
        for (int l = 0; l < SIMD_DEGREE; l++) begin
            prod[l] = i_data[l] * i_coef[l];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (o_accept) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;   // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (o_accept) begin
            o_data <= prod;
        end
    end

endmodule

// ==== design/vector_datapath.sv ====
`timescale 1ns/1ps

module vector_datapath #(
    parameter int SIMD_DEGREE = 4,
    parameter int NUM_COL     = 3,
    parameter int VRF_DEPTH   = 4,
    parameter int FIFO_DEPTH  = 16
) (
    input  logic                             clk,
    input  logic                             i_rst,
    // input stream
    input  vdp_pkg::lane_t [SIMD_DEGREE-1:0] i_in_data,
    input  logic                             i_in_valid,
    output logic                             o_in_ready,
    // output stream
    output vdp_pkg::lane_t [SIMD_DEGREE-1:0] o_out_data,
    output logic                             o_out_valid,
    input  logic                             i_out_ready,
    // instruction port, four-phase req/ack
    input  vdp_pkg::vop_e                    i_instr_op,
    input  logic [vdp_pkg::COL_W-1:0]        i_instr_col,
    input  logic [vdp_pkg::IDX_W-1:0]        i_instr_idx,
    input  vdp_pkg::lane_t                   i_instr_imm,
    input  logic                             i_instr_req,
    output logic                             o_instr_ack
);

    import vdp_pkg::*;

    typedef lane_t [SIMD_DEGREE-1:0] vec_t;

    logic in_full;
    logic in_empty;
    logic out_full;
    logic out_empty;

    // stage k feeds stage k+1, index 0 is the input FIFO head
    vec_t               stg_data [NUM_COL+1];
    logic [NUM_COL:0]   stg_valid;
    logic [NUM_COL:0]   stg_ready;

    vec_t               col_coef [NUM_COL];
    logic [NUM_COL-1:0] col_accept;

    // loader to columns
    logic [NUM_COL-1:0] col_we;
    vop_e               ld_op;
    logic [IDX_W-1:0]   ld_idx;
    lane_t              ld_imm;

    stream_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (vec_t)
    ) stream_fifo_in_inst (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_push  (i_in_valid && !in_full),
        .i_pop   (stg_valid[0] && stg_ready[0]),
        .i_din   (i_in_data),
        .o_dout  (stg_data[0]),
        .o_full  (in_full),
        .o_empty (in_empty)
    );

    assign o_in_ready   = !in_full;
    assign stg_valid[0] = !in_empty;

    instr_loader #(
        .NUM_COL (NUM_COL)
    ) instr_loader_inst (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_req    (i_instr_req),
        .i_op     (i_instr_op),
        .i_col    (i_instr_col),
        .i_idx    (i_instr_idx),
        .i_imm    (i_instr_imm),
        .o_ack    (o_instr_ack),
        .o_col_we (col_we),
        .o_op     (ld_op),
        .o_idx    (ld_idx),
        .o_imm    (ld_imm)
    );

    genvar j;
    generate
        for (j = 0; j < NUM_COL; j++) begin : g_col
            coef_regfile #(
                .SIMD_DEGREE (SIMD_DEGREE),
                .VRF_DEPTH   (VRF_DEPTH)
            ) coef_regfile_inst (
                .clk      (clk),
                .i_rst    (i_rst),
                .i_we     (col_we[j]),
                .i_op     (ld_op),
                .i_idx    (ld_idx),
                .i_imm    (ld_imm),
                .i_accept (col_accept[j]),
                .o_coef   (col_coef[j])
            );

            vec_pe #(
                .SIMD_DEGREE (SIMD_DEGREE)
            ) vec_pe_inst (
                .clk      (clk),
                .i_rst    (i_rst),
                .i_valid  (stg_valid[j]),
                .o_ready  (stg_ready[j]),
                .i_data   (stg_data[j]),
                .i_coef   (col_coef[j]),
                .o_accept (col_accept[j]),
                .o_valid  (stg_valid[j+1]),
                .i_ready  (stg_ready[j+1]),
                .o_data   (stg_data[j+1])
            );
        end
    endgenerate

    // last stage drains into the output FIFO while it has room
    assign stg_ready[NUM_COL] = !out_full;

    stream_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (vec_t)
    ) stream_fifo_out_inst (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_push  (stg_valid[NUM_COL] && !out_full),
        .i_pop   (i_out_ready && !out_empty),
        .i_din   (stg_data[NUM_COL]),
        .o_dout  (o_out_data),
        .o_full  (out_full),
        .o_empty (out_empty)
    );

    assign o_out_valid = !out_empty;

endmodule

// ==== files.f ====
design/vdp_pkg.sv
design/stream_fifo.sv
design/instr_loader.sv
design/coef_regfile.sv
design/vec_pe.sv
design/vector_datapath.sv
testbench/vdp_assert.sv
testbench/tb_vector_datapath.sv

// ==== testbench/tb_vector_datapath.sv ====
`timescale 1ns/1ps

module tb_vector_datapath;

    import vdp_pkg::*;

    localparam int SIMD_DEGREE = 4;
    localparam int NUM_COL     = 3;
    localparam int VRF_DEPTH   = 4;
    localparam int NUM_ROWS    = 7;
    localparam int TIMEOUT     = 200;  // cycles allowed per wait
    localparam int HOLD        = 60;   // output stall at the start of a back-pressure row

    typedef lane_t [SIMD_DEGREE-1:0] vec_t;

    logic             clk;
    logic             i_rst;
    vec_t             i_in_data;
    logic             i_in_valid;
    logic             o_in_ready;
    vec_t             o_out_data;
    logic             o_out_valid;
    logic             i_out_ready;
    vop_e             i_instr_op;
    logic [COL_W-1:0] i_instr_col;
    logic [IDX_W-1:0] i_instr_idx;
    lane_t            i_instr_imm;
    logic             i_instr_req;
    logic             o_instr_ack;

    // bit c of row_mul set when column c multiplies
    // coefficients packed per column as entries e3..e0
    bit          row_load  [NUM_ROWS] = '{0, 1, 1, 1, 1, 1, 1};
    bit [2:0]    row_mul   [NUM_ROWS] = '{3'd0, 3'd1, 3'd2, 3'd2, 3'd7, 3'd7, 3'd0};
    int          row_iter  [NUM_ROWS][NUM_COL] =
        '{'{1, 1, 1}, '{1, 1, 1}, '{1, 3, 1}, '{1, 3, 1}, '{2, 4, 3}, '{2, 4, 3}, '{1, 1, 1}};
    logic [63:0] row_coef  [NUM_ROWS][NUM_COL] = '{
        '{64'h0, 64'h0, 64'h0},
        '{64'hf00d, 64'h0, 64'h0},                                   // wraps past 16 bits
        '{64'h0, 64'h0005_0003_0002, 64'h0},
        '{64'h0, 64'h0005_0003_0002, 64'h0},                         // reload restarts at e0
        '{64'h0101_0003, 64'hfffd_000d_000b_0007, 64'h8001_0010_002b},
        '{64'h0101_0003, 64'hfffd_000d_000b_0007, 64'h8001_0010_002b},
        '{64'h0, 64'h0, 64'h0}
    };
    int          row_beats [NUM_ROWS] = '{20, 24, 31, 25, 40, 64, 48};
    bit          row_bp    [NUM_ROWS] = '{0, 0, 0, 0, 0, 1, 1};

    vec_t        exp_q [$];        // expected output beats in arrival order
    int          m_ptr [NUM_COL];  // model read pointer per column
    int          cur;              // row being run
    int          err_count  = 0;
    int          fail_count = 0;
    bit          stall_seen;

    vector_datapath dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            err_count++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    // samples ack between edges and returns just after a rising edge
    task automatic wait_ack(input logic level, input string what);
        int cyc;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (o_instr_ack !== level && cyc < TIMEOUT);
        if (o_instr_ack !== level) begin
            $display("instruction handshake stuck, %s not seen in %0d cycles", what, TIMEOUT);
            fail_count++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_instr(input vop_e op, input int col, input int idx, input lane_t imm);
        i_instr_op  = op;
        i_instr_col = COL_W'(col);
        i_instr_idx = IDX_W'(idx);
        i_instr_imm = imm;
        i_instr_req = 1'b1;
        wait_ack(1'b1, "ack high");
        i_instr_req = 1'b0;
        wait_ack(1'b0, "ack low");
    endtask

    task automatic load_row(input int r);
        for (int c = 0; c < NUM_COL; c++) begin
            if (row_mul[r][c]) begin
                for (int e = 0; e < VRF_DEPTH; e++) begin
                    send_instr(VOP_VMV, c, e, row_coef[r][c][16*e +: 16]);
                end
                send_instr(VOP_VMUL, c, 0, lane_t'(row_iter[r][c]));
            end else begin
                send_instr(VOP_PASS, c, 0, '0);
            end
            m_ptr[c] = 0;  // any mode load restarts the pointer
        end
        // column code past the last column
        send_instr(VOP_VMV, NUM_COL, 0, 16'hdead);
        send_instr(VOP_VMUL, NUM_COL, 0, 16'd2);
    endtask

    // expected beat after all columns with each product taken modulo 2^16
    task automatic model_step(input vec_t din, output vec_t dout);
        logic [31:0] prod;
        lane_t       coef;
        dout = din;
        for (int c = 0; c < NUM_COL; c++) begin
            if (row_mul[cur][c]) begin
                coef = row_coef[cur][c][16*m_ptr[c] +: 16];
                for (int l = 0; l < SIMD_DEGREE; l++) begin
                    prod    = 32'(dout[l]) * 32'(coef);
                    dout[l] = lane_t'(prod % 32'h1_0000);
                end
                m_ptr[c] = (m_ptr[c] + 1) % row_iter[cur][c];
            end
        end
    endtask

    task automatic drive_beats(input int n);
        vec_t din;
        vec_t dexp;
        int   cyc;
        bit   sent;
        for (int b = 0; b < n; b++) begin
            for (int l = 0; l < SIMD_DEGREE; l++) begin
                din[l] = lane_t'($urandom());
            end
            model_step(din, dexp);
            i_in_data  = din;
            i_in_valid = 1'b1;
            cyc = 0;
            do begin
                @(negedge clk);
                cyc++;
                sent = o_in_ready;  // transfer on the coming edge
                @(posedge clk);
                #1;
            end while (!sent && cyc < TIMEOUT);
            if (!sent) begin
                $display("input beat %0d not accepted within %0d cycles", b, TIMEOUT);
                fail_count++;
                break;
            end
            exp_q.push_back(dexp);
        end
        i_in_valid = 1'b0;
    endtask

    task automatic collect_beats(input int n, input bit bp);
        int   rcv;
        int   idle;
        int   cyc;
        bit   next_rdy;
        vec_t dexp;
        rcv  = 0;
        idle = 0;
        cyc  = 0;
        i_out_ready = !bp;
        while (rcv < n && idle < TIMEOUT) begin
            @(negedge clk);
            if (!o_in_ready) begin
                stall_seen = 1'b1;
            end
            if (o_out_valid && i_out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat at %0t arrived with none expected", $time);
                    fail_count++;
                end else begin
                    dexp = exp_q.pop_front();
                    check_val("output beat", 64'(o_out_data), 64'(dexp));
                end
                rcv++;
                idle = 0;
            end else begin
                idle++;
            end
            cyc++;
            if (!bp) begin
                next_rdy = 1'b1;
            end else if (cyc < HOLD) begin
                next_rdy = 1'b0;  // let both FIFOs fill
            end else begin
                next_rdy = ($urandom() % 3) != 0;
            end
            @(posedge clk);
            #1;
            i_out_ready = next_rdy;
        end
        if (rcv < n) begin
            $display("%0d of %0d output beats missing in row %0d", n - rcv, n, cur);
            fail_count++;
        end
        i_out_ready = 1'b1;
    endtask

    initial begin
        void'($urandom(32'hd8e8_5f15));
        i_rst       = 1'b1;
        i_in_data   = '0;
        i_in_valid  = 1'b0;
        i_out_ready = 1'b1;
        i_instr_op  = VOP_PASS;
        i_instr_col = '0;
        i_instr_idx = '0;
        i_instr_imm = '0;
        i_instr_req = 1'b0;
        for (int c = 0; c < NUM_COL; c++) begin
            m_ptr[c] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        i_rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur = r;
            if (row_load[r]) begin
                load_row(r);
            end
            stall_seen = 1'b0;
            fork
                drive_beats(row_beats[r]);
                collect_beats(row_beats[r], row_bp[r]);
            join
            if (row_bp[r]) begin
                check_val("o_in_ready low under back-pressure", 64'(stall_seen), 64'd1);
            end
            exp_q.delete();
        end
        $display("errors: %0d value mismatches, %0d protocol failures", err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== testbench/vdp_assert.sv ====
`timescale 1ns/1ps

module vdp_assert #(
    parameter int DATA_W = 64
) (
    input logic              clk,
    input logic              i_rst,
    input logic              i_instr_req,
    input logic              i_instr_ack,
    input logic              i_out_valid,
    input logic              i_out_ready,
    input logic [DATA_W-1:0] i_out_data
);

    // four-phase ack follows req
    ack_rise_a: assert property (@(posedge clk) disable iff (i_rst)
        $rose(i_instr_ack) |-> $past(i_instr_req))
        else $error("o_instr_ack rose while i_instr_req was low");

    ack_fall_a: assert property (@(posedge clk) disable iff (i_rst)
        $fell(i_instr_ack) |-> !$past(i_instr_req))
        else $error("o_instr_ack fell while i_instr_req was high");

    // a stalled output beat holds until taken
    out_hold_a: assert property (@(posedge clk) disable iff (i_rst)
        i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_data))
        else $error("output beat changed or dropped before transfer");

    out_reset_a: assert property (@(posedge clk) i_rst |=> !i_out_valid)
        else $error("o_out_valid high after a reset cycle");

endmodule

bind vector_datapath vdp_assert #(
    .DATA_W (SIMD_DEGREE * vdp_pkg::LANE_W)
) vdp_assert_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_instr_req (i_instr_req),
    .i_instr_ack (o_instr_ack),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_out_data  (o_out_data)
);
